//--- sources.f
hdl/obi_sl_pkg.sv
hdl/obi_phase_monitor.sv
hdl/gntpar_check.sv
hdl/req_attr_fifo.sv
hdl/sl_csr.sv
hdl/obi_support_top.sv
verif/tb_obi_support.sv

//--- Makefile
TOP := tb_obi_support

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f sources.f --top-module obi_support_top
	verilator --lint-only --timing --timescale 1ns/100ps -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- verif/tb_obi_support.sv
// OBI support logic testbench

module tb_obi_support;

  timeunit 1ns;
  timeprecision 100ps;

  import obi_sl_pkg::*;

  localparam int FIFO_DEPTH   = 4;
  localparam int COUNT_W      = 8;
  localparam int CNT_MAX      = (1 << COUNT_W) - 1;
  localparam int CLK_PERIOD   = 20;
  localparam int RUN_STEPS    = 200;
  localparam int FREEZE_STEPS = 60;
  localparam int SAT_RESPS    = 300;
  // each bus phase at a slow rate plus drains and register traffic
  localparam int WATCHDOG_CYCLES = 4 * (RUN_STEPS + FREEZE_STEPS + 8 * SAT_RESPS) + 1000;

  // counter slots of the model
  localparam int C_RESP  = 0;
  localparam int C_STORE = 1;
  localparam int C_ERR   = 2;
  localparam int C_VIOL  = 3;

  logic                  in_support_if;
  logic                  rst_n_i;
  logic                  obi_req_i, obi_gnt_i, obi_gntpar_i, obi_rvalid_i;
  logic                  req_is_store_i, req_integrity_i;
  logic                  cmd_valid_i, cmd_write_i, rsp_ready_i;
  logic [REG_ADDR_W-1:0] cmd_addr_i;
  logic [DATA_W-1:0]     cmd_wdata_i;
  logic                  cmd_ready_o, rsp_valid_o;
  sl_word_u              rsp_rdata_o;
  attr_t                 resp_attr_o;
  logic [7:0]            outstanding_o;
  logic                  addr_ph_cont_o, resp_ph_cont_o;

  // reference model state
  logic [31:0] lfsr = 32'hbd05_a140;
  attr_t       m_q[$];
  int          m_out;
  int          m_cnt [4];
  int          total_resp;
  logic        m_en, m_held, m_prev_req, m_prev_gnt, m_prev_wait;

  obi_support_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .COUNT_W    (COUNT_W)
  ) DUT (.*);

  always #(CLK_PERIOD / 2) in_support_if = ~in_support_if;

  // ---------------------------------------------------------------------------
  // random source and checks
  // ---------------------------------------------------------------------------

  // galois lfsr stepped once per bit taken
  function automatic logic rand_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic int rand_val(input int nbits);
    int v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_attr(input string name, input attr_t exp, input attr_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input sl_word_u exp, input sl_word_u act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  function automatic void count_event(input int idx, input logic hit);
    if (hit && m_en && (m_cnt[idx] < CNT_MAX)) begin
      m_cnt[idx]++;
    end
  endfunction

  function automatic sl_word_u cnt_word(input int v);
    sl_word_u w;
    w.value = 32'(v);
    return w;
  endfunction

  // status as seen with the bus idle
  function automatic sl_word_u status_word();
    sl_word_u w;
    w = '0;
    w.status.outstanding  = 8'(m_out);
    w.status.level        = 8'(m_q.size());
    w.status.resp_ph_cont = (m_out > 0);
    w.status.count_en     = m_en;
    return w;
  endfunction

  task automatic next_cycle();
    @(posedge in_support_if);
    #2;
  endtask

  // ---------------------------------------------------------------------------
  // bus stimulus and model
  // ---------------------------------------------------------------------------

  task automatic bus_step(input bit new_reqs, input bit rv_en, input bit force_rv);
    attr_t exp_attr;
    attr_t new_attr;
    logic  inj;
    logic  bad;
    next_cycle();
    // master keeps an ungranted request
    if (!(obi_req_i && !obi_gnt_i)) begin
      obi_req_i       = new_reqs && (rand_val(2) != 0);
      req_is_store_i  = rand_bit();
      req_integrity_i = rand_bit();
    end
    obi_gnt_i    = obi_req_i && (m_out < FIFO_DEPTH) && rand_bit();
    inj          = (rand_val(3) == 0);
    obi_gntpar_i = inj ? obi_gnt_i : !obi_gnt_i;
    obi_rvalid_i = force_rv || (rv_en && (m_out > 0) && rand_bit());
    @(negedge in_support_if);
    check_count("outstanding_o", 8'(m_out), outstanding_o);
    check_flag("addr_ph_cont_o", obi_req_i && m_prev_req && !m_prev_gnt, addr_ph_cont_o);
    check_flag("resp_ph_cont_o", (m_out > 0) && m_prev_wait, resp_ph_cont_o);
    // an injected parity error sticks until the request is granted
    bad = obi_req_i && (inj || m_held);
    m_prev_wait = (m_out > 0) && !obi_rvalid_i;
    if (obi_rvalid_i) begin
      exp_attr = (m_out > 0) ? m_q.pop_front() : attr_t'('0);
      check_attr("resp_attr_o", exp_attr, resp_attr_o);
      count_event(C_RESP, 1'b1);
      count_event(C_STORE, exp_attr.store);
      count_event(C_ERR, exp_attr.gntpar_err);
      count_event(C_VIOL, m_out == 0);
      if (m_out > 0) begin
        m_out--;
        total_resp++;
      end
    end
    if (obi_req_i && obi_gnt_i) begin
      new_attr.store      = req_is_store_i;
      new_attr.integrity  = req_integrity_i;
      new_attr.gntpar_err = bad;
      m_q.push_back(new_attr);
      m_out++;
    end
    m_held     = obi_req_i && !obi_gnt_i && bad;
    m_prev_req = obi_req_i;
    m_prev_gnt = obi_gnt_i;
  endtask

  // answer everything and leave the bus idle
  task automatic drain();
    while ((m_out > 0) || obi_req_i || obi_rvalid_i) begin
      bus_step(1'b0, 1'b1, 1'b0);
    end
  endtask

  // ---------------------------------------------------------------------------
  // register port
  // ---------------------------------------------------------------------------

  task automatic reg_access(input logic wr, input logic [REG_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input sl_word_u exp);
    sl_word_u first;
    int       waited;
    next_cycle();
    cmd_valid_i = 1'b1;
    cmd_write_i = wr;
    cmd_addr_i  = addr;
    cmd_wdata_i = wdata;
    waited      = 0;
    @(negedge in_support_if);
    while (!cmd_ready_o) begin
      waited++;
      if (waited > 8) begin
        stop_on_error("register port never accepted the command");
      end
      @(negedge in_support_if);
    end
    // response due one cycle after the handshake
    next_cycle();
    // a read of another register waits on the port while the response is pending
    cmd_write_i = 1'b0;
    cmd_addr_i  = addr + 1'b1;
    rsp_ready_i = rand_bit();
    @(negedge in_support_if);
    check_flag("rsp_valid_o", 1'b1, rsp_valid_o);
    check_flag("cmd_ready_o", 1'b0, cmd_ready_o);
    first = rsp_rdata_o;
    check_word("rsp_rdata_o", exp, first);
    // a stalled response holds and blocks new commands
    while (!rsp_ready_i) begin
      next_cycle();
      rsp_ready_i = rand_bit();
      @(negedge in_support_if);
      check_flag("rsp_valid_o", 1'b1, rsp_valid_o);
      check_flag("cmd_ready_o", 1'b0, cmd_ready_o);
      check_word("rsp_rdata_o", first, rsp_rdata_o);
    end
    // withdraw the waiting read before the port frees up
    next_cycle();
    cmd_valid_i = 1'b0;
    if (wr && (addr == REG_CTRL)) begin
      m_en = wdata[0];
      if (wdata[1]) begin
        m_cnt = '{0, 0, 0, 0};
      end
    end
  endtask

  task automatic read_counters();
    reg_access(1'b0, REG_RESP_CNT, '0, cnt_word(m_cnt[C_RESP]));
    reg_access(1'b0, REG_STORE_CNT, '0, cnt_word(m_cnt[C_STORE]));
    reg_access(1'b0, REG_ERR_CNT, '0, cnt_word(m_cnt[C_ERR]));
    reg_access(1'b0, REG_VIOL_CNT, '0, cnt_word(m_cnt[C_VIOL]));
  endtask

  // ---------------------------------------------------------------------------
  // sequence
  // ---------------------------------------------------------------------------

  initial begin
    in_support_if   = 1'b0;
    rst_n_i         = 1'b0;
    obi_req_i       = 1'b0;
    obi_gnt_i       = 1'b0;
    obi_gntpar_i    = 1'b1;
    obi_rvalid_i    = 1'b0;
    req_is_store_i  = 1'b0;
    req_integrity_i = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_write_i     = 1'b0;
    cmd_addr_i      = '0;
    cmd_wdata_i     = '0;
    rsp_ready_i     = 1'b0;
    m_out           = 0;
    m_cnt           = '{0, 0, 0, 0};
    total_resp      = 0;
    m_en            = 1'b1;
    m_held          = 1'b0;
    m_prev_req      = 1'b0;
    m_prev_gnt      = 1'b0;
    m_prev_wait     = 1'b0;
    repeat (4) @(posedge in_support_if);
    #2;
    rst_n_i = 1'b1;
    @(negedge in_support_if);
    check_flag("cmd_ready_o", 1'b1, cmd_ready_o);
    check_flag("rsp_valid_o", 1'b0, rsp_valid_o);
    check_flag("addr_ph_cont_o", 1'b0, addr_ph_cont_o);
    check_flag("resp_ph_cont_o", 1'b0, resp_ph_cont_o);
    reg_access(1'b0, REG_STATUS, '0, status_word());

    repeat (RUN_STEPS) bus_step(1'b1, 1'b1, 1'b0);
    drain();
    read_counters();

    // clear with counting kept on and then freeze during traffic
    reg_access(1'b1, REG_CTRL, 32'h3, '0);
    read_counters();
    reg_access(1'b1, REG_CTRL, 32'h0, '0);
    repeat (FREEZE_STEPS) bus_step(1'b1, 1'b1, 1'b0);
    drain();
    read_counters();
    reg_access(1'b1, REG_CTRL, 32'h1, '0);

    // enough responses to saturate
    total_resp = 0;
    while (total_resp < SAT_RESPS) begin
      bus_step(1'b1, 1'b1, 1'b0);
    end
    drain();
    read_counters();

    // response with nothing outstanding
    bus_step(1'b0, 1'b1, 1'b1);
    drain();
    read_counters();

    // status with requests still pending
    while (m_out < 2) begin
      bus_step(1'b1, 1'b0, 1'b0);
    end
    while (obi_req_i) begin
      bus_step(1'b0, 1'b0, 1'b0);
    end
    reg_access(1'b0, REG_STATUS, '0, status_word());
    drain();
    reg_access(1'b0, REG_STATUS, '0, status_word());

    $display("Testbench passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error("watchdog expired before the test sequence finished");
  end

endmodule : tb_obi_support

//--- hdl/obi_support_top.sv
// OBI support logic top level

module obi_support_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int COUNT_W    = 8
) (
  input  logic                              in_support_if,
  input  logic                              rst_n_i,
  // observed data bus
  input  logic                              obi_req_i,
  input  logic                              obi_gnt_i,
  input  logic                              obi_gntpar_i,
  input  logic                              obi_rvalid_i,
  input  logic                              req_is_store_i,
  input  logic                              req_integrity_i,
  // register port
  input  logic                              cmd_valid_i,
  output logic                              cmd_ready_o,
  input  logic                              cmd_write_i,
  input  logic [obi_sl_pkg::REG_ADDR_W-1:0] cmd_addr_i,
  input  logic [obi_sl_pkg::DATA_W-1:0]     cmd_wdata_i,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output obi_sl_pkg::sl_word_u              rsp_rdata_o,
  // observations
  output obi_sl_pkg::attr_t                 resp_attr_o,
  output logic [7:0]                        outstanding_o,
  output logic                              addr_ph_cont_o,
  output logic                              resp_ph_cont_o
);

  import obi_sl_pkg::*;

  logic       gntpar_err;
  logic       viol;
  logic [7:0] level;
  attr_t      req_attr;

  // entry captured at grant
  assign req_attr = '{store: req_is_store_i, integrity: req_integrity_i, gntpar_err: gntpar_err};

  obi_phase_monitor u_phase_mon (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .req_i          (obi_req_i),
    .gnt_i          (obi_gnt_i),
    .rvalid_i       (obi_rvalid_i),
    .addr_ph_cont_o (addr_ph_cont_o),
    .resp_ph_cont_o (resp_ph_cont_o),
    .viol_o         (viol),
    .outstanding_o  (outstanding_o)
  );

  gntpar_check u_gntpar (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (obi_req_i),
    .gnt_i         (obi_gnt_i),
    .gntpar_i      (obi_gntpar_i),
    .gntpar_err_o  (gntpar_err)
  );

  req_attr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_attr_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .push_i        (obi_req_i & obi_gnt_i),
    .pop_i         (obi_rvalid_i),
    .attr_i        (req_attr),
    .attr_o        (resp_attr_o),
    .level_o       (level)
  );

  sl_csr #(
    .COUNT_W (COUNT_W)
  ) u_csr (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_write_i    (cmd_write_i),
    .rsp_ready_i    (rsp_ready_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_wdata_i    (cmd_wdata_i),
    .cmd_ready_o    (cmd_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .resp_evt_i     (obi_rvalid_i),
    .viol_i         (viol),
    .resp_attr_i    (resp_attr_o),
    .outstanding_i  (outstanding_o),
    .level_i        (level),
    .addr_ph_cont_i (addr_ph_cont_o),
    .resp_ph_cont_i (resp_ph_cont_o)
  );

endmodule : obi_support_top

//--- hdl/sl_csr.sv
// Support logic register block

module sl_csr #(
  parameter int COUNT_W = 8
) (
  input  logic                              in_support_if,
  input  logic                              rst_n_i,
  input  logic                              cmd_valid_i,
  input  logic                              cmd_write_i,
  input  logic                              rsp_ready_i,
  input  logic [obi_sl_pkg::REG_ADDR_W-1:0] cmd_addr_i,
  input  logic [obi_sl_pkg::DATA_W-1:0]     cmd_wdata_i,
  output logic                              cmd_ready_o,
  output logic                              rsp_valid_o,
  output obi_sl_pkg::sl_word_u              rsp_rdata_o,
  input  logic                              resp_evt_i,
  input  logic                              viol_i,
  input  obi_sl_pkg::attr_t                 resp_attr_i,
  input  logic [7:0]                        outstanding_i,
  input  logic [7:0]                        level_i,
  input  logic                              addr_ph_cont_i,
  input  logic                              resp_ph_cont_i
);

  import obi_sl_pkg::*;

  localparam int NUM_CNT   = 4;
  localparam int CNT_RESP  = 0;
  localparam int CNT_STORE = 1;
  localparam int CNT_ERR   = 2;
  localparam int CNT_VIOL  = 3;

  logic               count_en_q;
  logic               rsp_valid_q;
  sl_word_u           rsp_word_q;
  logic [COUNT_W-1:0] cnt_q [NUM_CNT];

  logic               cmd_fire;
  logic               clr_pulse;
  logic [NUM_CNT-1:0] evt;
  sl_word_u           rd_word;

  assign cmd_ready_o = !rsp_valid_q;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  // ctrl bit 1 clears all counters
  assign clr_pulse = cmd_fire && cmd_write_i && (cmd_addr_i == REG_CTRL) && cmd_wdata_i[1];

  assign evt[CNT_RESP]  = resp_evt_i;
  assign evt[CNT_STORE] = resp_evt_i && resp_attr_i.store;
  assign evt[CNT_ERR]   = resp_evt_i && resp_attr_i.gntpar_err;
  assign evt[CNT_VIOL]  = viol_i;

  // --------------------------------------------------------------------------
  // control and saturating counters
  // --------------------------------------------------------------------------

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_en_q <= 1'b1;
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      if (cmd_fire && cmd_write_i && (cmd_addr_i == REG_CTRL)) begin
        count_en_q <= cmd_wdata_i[0];
      end
      for (int i = 0; i < NUM_CNT; i++) begin
        if (clr_pulse) begin
          cnt_q[i] <= '0;
        end else if (count_en_q && evt[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // read decode and response
  // --------------------------------------------------------------------------

  always_comb begin
    rd_word = '0;
    case (cmd_addr_i)
      REG_CTRL:      rd_word.value = DATA_W'(count_en_q);
      REG_RESP_CNT:  rd_word.value = DATA_W'(cnt_q[CNT_RESP]);
      REG_STORE_CNT: rd_word.value = DATA_W'(cnt_q[CNT_STORE]);
      REG_ERR_CNT:   rd_word.value = DATA_W'(cnt_q[CNT_ERR]);
      REG_VIOL_CNT:  rd_word.value = DATA_W'(cnt_q[CNT_VIOL]);
      REG_STATUS: begin
        rd_word.status.outstanding  = outstanding_i;
        rd_word.status.level        = level_i;
        rd_word.status.addr_ph_cont = addr_ph_cont_i;
        rd_word.status.resp_ph_cont = resp_ph_cont_i;
        rd_word.status.count_en     = count_en_q;
      end
      default:       rd_word = '0;
    endcase
  end

  // response holds until it is taken
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (cmd_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // writes answer with an empty word
  always_ff @(posedge in_support_if) begin
    if (cmd_fire) begin
      rsp_word_q <= cmd_write_i ? sl_word_u'('0) : rd_word;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_word_q;

endmodule : sl_csr

//--- hdl/req_attr_fifo.sv
// Request attribute queue

module req_attr_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              in_support_if,
  input  logic              rst_n_i,
  input  logic              push_i,
  input  logic              pop_i,
  input  obi_sl_pkg::attr_t attr_i,
  output obi_sl_pkg::attr_t attr_o,
  output logic [7:0]        level_o
);

  import obi_sl_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [ATTR_W-1:0] mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W:0]    count_q;

  logic              empty;
  logic              full;
  logic              do_push;
  logic              do_pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == (PTR_W+1)'(FIFO_DEPTH));

  // a pop on an empty queue is ignored
  assign do_pop  = pop_i && !empty;
  // a full queue still accepts when an entry leaves in the same cycle
  assign do_push = push_i && (!full || do_pop);

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------

  always_ff @(posedge in_support_if) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= attr_i;
    end
  end

  // --------------------------------------------------------------------------
  // pointers and level
  // --------------------------------------------------------------------------

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // depth is a power of two, so the pointers wrap on their own
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // oldest unanswered grant, zero when nothing is queued
  assign attr_o  = empty ? attr_t'('0) : attr_t'(mem_q[rd_ptr_q]);
  assign level_o = 8'(count_q);

endmodule : req_attr_fifo

//--- hdl/gntpar_check.sv
// Grant parity checker

module gntpar_check (
  input  logic in_support_if,
  input  logic rst_n_i,
  input  logic req_i,
  input  logic gnt_i,
  input  logic gntpar_i,
  output logic gntpar_err_o
);

  // error seen earlier in the current, still ungranted, address phase
  logic err_held_q;
  logic par_bad;

  // gntpar must be the inverse of gnt
  assign par_bad = (gnt_i == gntpar_i);

  assign gntpar_err_o = req_i && (par_bad || err_held_q);

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_held_q <= 1'b0;
    end else begin
      if (req_i && !gnt_i) begin
        // stalled cycle, keep what has been seen so far
        err_held_q <= gntpar_err_o;
      end else begin
        // granted or idle, next request starts clean
        err_held_q <= 1'b0;
      end
    end
  end

endmodule : gntpar_check

//--- hdl/obi_phase_monitor.sv
// OBI phase monitor

module obi_phase_monitor (
  input  logic       in_support_if,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  logic       gnt_i,
  input  logic       rvalid_i,
  output logic       addr_ph_cont_o,
  output logic       resp_ph_cont_o,
  output logic       viol_o,
  output logic [7:0] outstanding_o
);

  // previous cycle of the address phase
  logic       req_q;
  logic       gnt_q;
  // previous cycle was waiting on a response
  logic       resp_wait_q;
  logic [7:0] outstanding_q;

  logic       addr_done;
  logic       resp_done;
  logic       no_pending;
  logic       req_dropped;

  assign no_pending = (outstanding_q == 8'd0);
  assign addr_done  = req_i && gnt_i;
  // a response with nothing pending is a violation and is not counted down
  assign resp_done  = rvalid_i && !no_pending;

  // request withdrawn before it was granted
  assign req_dropped = !req_i && req_q && !gnt_q;

  // --------------------------------------------------------------------------
  // history and outstanding count
  // --------------------------------------------------------------------------

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q         <= 1'b0;
      gnt_q         <= 1'b0;
      resp_wait_q   <= 1'b0;
      outstanding_q <= 8'd0;
    end else begin
      req_q       <= req_i;
      gnt_q       <= gnt_i;
      resp_wait_q <= !no_pending && !rvalid_i;

      // grant and response together leave the count unchanged
      if (addr_done && !resp_done) begin
        outstanding_q <= outstanding_q + 8'd1;
      end else if (!addr_done && resp_done) begin
        outstanding_q <= outstanding_q - 8'd1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------

  // req held from a cycle that was not granted
  assign addr_ph_cont_o = req_i && req_q && !gnt_q;

  // still waiting after a cycle that was already waiting
  assign resp_ph_cont_o = !no_pending && resp_wait_q;

  assign viol_o = (rvalid_i && no_pending) || req_dropped;

  assign outstanding_o = outstanding_q;

endmodule : obi_phase_monitor

//--- hdl/obi_sl_pkg.sv
// OBI support logic definitions

package obi_sl_pkg;

  // --------------------------------------------------------------------------
  // request attributes
  // --------------------------------------------------------------------------

  // one queue entry per granted request
  localparam int ATTR_W = 3;

  typedef struct packed {
    logic store;
    logic integrity;
    logic gntpar_err;
  } attr_t;

  // --------------------------------------------------------------------------
  // register port
  // --------------------------------------------------------------------------

  localparam int REG_ADDR_W = 3;
  localparam int DATA_W     = 32;

  localparam logic [REG_ADDR_W-1:0] REG_CTRL      = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_RESP_CNT  = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_STORE_CNT = 3'd3;
  localparam logic [REG_ADDR_W-1:0] REG_ERR_CNT   = 3'd4;
  localparam logic [REG_ADDR_W-1:0] REG_VIOL_CNT  = 3'd5;

  // read word, seen as a plain counter value or as the status layout
  typedef union packed {
    logic [DATA_W-1:0] value;
    struct packed {
      logic [12:0] reserved;
      logic        count_en;
      logic        resp_ph_cont;
      logic        addr_ph_cont;
      logic [7:0]  level;
      logic [7:0]  outstanding;
    } status;
  } sl_word_u;

endpackage : obi_sl_pkg
